/* all.f */
hdl/mem_bus_pkg.sv
hdl/cache_geom_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_arbiter.sv
hdl/line_memory.sv
hdl/cache_subsystem.sv
bench/tb_cache_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cache subsystem testbench with Verilator and runs it.
# A $fatal in the testbench gives a non-zero exit status.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cache_subsystem \
    -Mdir obj_dir -o sim_cache_subsystem &&
./obj_dir/sim_cache_subsystem ||
{ echo "Simulation run did not complete successfully"; exit 1; }

/* bench/tb_cache_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cache_subsystem
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
();

    localparam int unsigned CLK_PERIOD = 100;
    localparam int unsigned TIMEOUT    = 100;    // Cycles per request.
    localparam int unsigned HIT_CYCLES = 1;      // Falling edges from drive to ready.
    localparam int unsigned REF_WORDS  = 1024;   // Low 4 KB.
    localparam int unsigned MAX_ROWS   = 40;

    typedef enum logic [1:0] {SIDE_I, SIDE_D, SIDE_BOTH} side_e;
    typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_READ_HIT} op_e;

    logic              clk, rst_n;
    logic [ADDR_W-1:0] i_addr, d_addr;
    logic [WORD_W-1:0] i_wdata, d_wdata, i_rdata, d_rdata;
    logic              i_rw, d_rw, i_valid, d_valid, i_ready, d_ready;

    // ******************************
    // Stimulus table
    // ******************************

    string             row_name [MAX_ROWS];
    side_e             row_side [MAX_ROWS];
    op_e               row_op   [MAX_ROWS];
    logic [ADDR_W-1:0] row_addr [MAX_ROWS];
    logic [WORD_W-1:0] row_data [MAX_ROWS];
    logic              row_conc [MAX_ROWS];   // Issued together with the next row.
    int unsigned       num_rows;

    logic [WORD_W-1:0] ref_mem [REF_WORDS];
    int                seed;
    int unsigned       k;

    cache_subsystem cache_subsystem_i (
        .clk_i        (clk),     .rst_ni       (rst_n),
        .i_cpu_addr_i (i_addr),  .i_cpu_wdata_i(i_wdata),
        .i_cpu_rw_i   (i_rw),    .i_cpu_valid_i(i_valid),
        .i_cpu_rdata_o(i_rdata), .i_cpu_ready_o(i_ready),
        .d_cpu_addr_i (d_addr),  .d_cpu_wdata_i(d_wdata),
        .d_cpu_rw_i   (d_rw),    .d_cpu_valid_i(d_valid),
        .d_cpu_rdata_o(d_rdata), .d_cpu_ready_o(d_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned ref_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[11:2]);
    endfunction

    task automatic add_row(input string name, input side_e side, input op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                           input logic conc);
        row_name[num_rows] = name;
        row_side[num_rows] = side;
        row_op[num_rows]   = op;
        row_addr[num_rows] = addr;
        row_data[num_rows] = data;
        row_conc[num_rows] = conc;
        num_rows++;
    endtask

    task automatic build_table();
        // Writes over several lines, then reads back.
        add_row("d_wr_line0_w0", SIDE_D, OP_WRITE, 32'h000, $random(seed), 1'b0);
        add_row("d_wr_line0_w2", SIDE_D, OP_WRITE, 32'h008, $random(seed), 1'b0);
        add_row("d_wr_line1_w1", SIDE_D, OP_WRITE, 32'h014, $random(seed), 1'b0);
        add_row("d_wr_line5_w3", SIDE_D, OP_WRITE, 32'h05C, $random(seed), 1'b0);
        add_row("d_rd_line0_w0", SIDE_D, OP_READ, 32'h000, '0, 1'b0);
        add_row("d_rd_line0_w2", SIDE_D, OP_READ, 32'h008, '0, 1'b0);
        add_row("d_rd_line0_w1_zero", SIDE_D, OP_READ, 32'h004, '0, 1'b0);
        add_row("d_rd_line1_w1", SIDE_D, OP_READ, 32'h014, '0, 1'b0);
        add_row("d_rd_line5_w3", SIDE_D, OP_READ, 32'h05C, '0, 1'b0);
        add_row("d_hit_line5_w3", SIDE_D, OP_READ_HIT, 32'h05C, '0, 1'b0);
        add_row("d_hit_line1_w1", SIDE_D, OP_READ_HIT, 32'h014, '0, 1'b0);
        // Same index, tags differ in bit 10.
        add_row("d_wr_tag_a", SIDE_D, OP_WRITE, 32'h0A4, $random(seed), 1'b0);
        add_row("d_wr_tag_b", SIDE_D, OP_WRITE, 32'h4A4, $random(seed), 1'b0);
        add_row("d_rd_tag_a", SIDE_D, OP_READ, 32'h0A4, '0, 1'b0);
        add_row("d_rd_tag_b", SIDE_D, OP_READ, 32'h4A4, '0, 1'b0);
        add_row("d_wr_tag_a2", SIDE_D, OP_WRITE, 32'h0A8, $random(seed), 1'b0);
        add_row("d_rd_tag_b2_zero", SIDE_D, OP_READ, 32'h4A8, '0, 1'b0);
        add_row("d_rd_tag_a2", SIDE_D, OP_READ, 32'h0A8, '0, 1'b0);
        add_row("d_rd_tag_a_again", SIDE_D, OP_READ, 32'h0A4, '0, 1'b0);
        // Instruction side sees data-side writes through memory.
        add_row("i_rd_line0_w2", SIDE_I, OP_READ, 32'h008, '0, 1'b0);
        add_row("i_rd_line1_w1", SIDE_I, OP_READ, 32'h014, '0, 1'b0);
        add_row("i_rd_tag_b", SIDE_I, OP_READ, 32'h4A4, '0, 1'b0);
        add_row("both_rd_line5", SIDE_BOTH, OP_READ, 32'h05C, '0, 1'b0);
        // Concurrent pairs.
        add_row("conc_i_rd_miss", SIDE_I, OP_READ, 32'h100, '0, 1'b1);
        add_row("conc_d_wr_miss", SIDE_D, OP_WRITE, 32'h200, $random(seed), 1'b0);
        add_row("conc_i_rd_hit", SIDE_I, OP_READ, 32'h014, '0, 1'b1);
        add_row("conc_d_rd_replace", SIDE_D, OP_READ, 32'h4A4, '0, 1'b0);
        add_row("conc_d_wr_line30", SIDE_D, OP_WRITE, 32'h300, $random(seed), 1'b1);
        add_row("conc_i_rd_d_line", SIDE_I, OP_READ, 32'h200, '0, 1'b0);
        add_row("conc_i_wr_line38", SIDE_I, OP_WRITE, 32'h380, $random(seed), 1'b1);
        add_row("conc_d_rd_line30", SIDE_D, OP_READ, 32'h300, '0, 1'b0);
        add_row("d_rd_i_written", SIDE_D, OP_READ, 32'h380, '0, 1'b0);
    endtask

    // ******************************
    // Checks
    // ******************************

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp_word,
                              input logic [WORD_W-1:0] act_word);
        if (act_word !== exp_word) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp_word, act_word);
            $display("Verification failed");
            $fatal(1, "Read data mismatch.");
        end
    endtask

    task automatic check_latency(input string name, input int unsigned exp_cycles,
                                 input int unsigned act_cycles);
        if (act_cycles != exp_cycles) begin
            $display("[ERROR] %s: expected %0d cycles, actual %0d", name, exp_cycles,
                     act_cycles);
            $display("Verification failed");
            $fatal(1, "Read hit latency mismatch.");
        end
    endtask

    task automatic check_idle(input string name, input logic i_rdy, input logic d_rdy);
        if (i_rdy !== 1'b0 || d_rdy !== 1'b0) begin
            $display("[ERROR] %s: expected ready %b, actual %b", name, 2'b00, {i_rdy, d_rdy});
            $display("Verification failed");
            $fatal(1, "Ready high while idle.");
        end
    endtask

    task automatic finish_side(input int unsigned idx, input logic [WORD_W-1:0] exp_word,
                               input logic [WORD_W-1:0] got_word, input int unsigned cyc);
        if (row_op[idx] == OP_WRITE) begin
            ref_mem[ref_index(row_addr[idx])] = row_data[idx];
        end else begin
            check_word(row_name[idx], exp_word, got_word);
            if (row_op[idx] == OP_READ_HIT) begin
                check_latency(row_name[idx], HIT_CYCLES, cyc);
            end
        end
    endtask

    // Issue one row per side, wait for each ready, drop valid at once.
    task automatic run_request(input logic use_i, input logic use_d,
                               input int unsigned ki, input int unsigned kd);
        logic [WORD_W-1:0] exp_i, exp_d, got_i, got_d;
        logic              pend_i, pend_d;
        int unsigned       cycles, cyc_i, cyc_d;
        string             name;

        name   = use_i ? row_name[ki] : row_name[kd];
        exp_i  = ref_mem[ref_index(row_addr[ki])];
        exp_d  = ref_mem[ref_index(row_addr[kd])];
        got_i  = '0;
        got_d  = '0;
        cyc_i  = 0;
        cyc_d  = 0;
        cycles = 0;
        pend_i = use_i;
        pend_d = use_d;
        if (use_i) begin
            i_addr  = row_addr[ki];
            i_wdata = row_data[ki];
            i_rw    = (row_op[ki] == OP_WRITE);
            i_valid = 1'b1;
        end
        if (use_d) begin
            d_addr  = row_addr[kd];
            d_wdata = row_data[kd];
            d_rw    = (row_op[kd] == OP_WRITE);
            d_valid = 1'b1;
        end
        while (pend_i || pend_d) begin
            if (cycles == TIMEOUT) begin
                $display("Request %s never completed within %0d cycles.", name, TIMEOUT);
                $display("Verification failed");
                $fatal(1, "Request timeout.");
            end
            @(negedge clk);
            cycles++;
            if (pend_i && i_ready) begin
                got_i   = i_rdata;
                cyc_i   = cycles;
                i_valid = 1'b0;
                pend_i  = 1'b0;
            end
            if (pend_d && d_ready) begin
                got_d   = d_rdata;
                cyc_d   = cycles;
                d_valid = 1'b0;
                pend_d  = 1'b0;
            end
        end
        if (use_i) begin
            finish_side(ki, exp_i, got_i, cyc_i);
        end
        if (use_d) begin
            finish_side(kd, exp_d, got_d, cyc_d);
        end
        @(negedge clk);
        check_idle(name, i_ready, d_ready);
    endtask

    initial begin
        seed     = 39576;
        num_rows = 0;
        rst_n    = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_rw     = 1'b0;
        i_valid  = 1'b0;
        d_addr   = '0;
        d_wdata  = '0;
        d_rw     = 1'b0;
        d_valid  = 1'b0;
        foreach (ref_mem[w]) ref_mem[w] = '0;
        build_table();

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        repeat (5) begin   // Quiet after reset.
            @(negedge clk);
            check_idle("idle_after_reset", i_ready, d_ready);
        end

        k = 0;
        while (k < num_rows) begin
            if (row_conc[k]) begin
                if (row_side[k] == SIDE_I) begin
                    run_request(1'b1, 1'b1, k, k + 1);
                end else begin
                    run_request(1'b1, 1'b1, k + 1, k);
                end
                k += 2;
            end else begin
                run_request(row_side[k] != SIDE_D, row_side[k] != SIDE_I, k, k);
                k += 1;
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cache_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic [ADDR_W-1:0] i_cpu_addr_i,
    input  wire logic [WORD_W-1:0] i_cpu_wdata_i,
    input  wire logic              i_cpu_rw_i,
    input  wire logic              i_cpu_valid_i,
    output logic      [WORD_W-1:0] i_cpu_rdata_o,
    output logic                   i_cpu_ready_o,

    input  wire logic [ADDR_W-1:0] d_cpu_addr_i,
    input  wire logic [WORD_W-1:0] d_cpu_wdata_i,
    input  wire logic              d_cpu_rw_i,
    input  wire logic              d_cpu_valid_i,
    output logic      [WORD_W-1:0] d_cpu_rdata_o,
    output logic                   d_cpu_ready_o
);

    // ******************************
    // Line bus wiring
    // ******************************

    logic [ADDR_W-1:0] i_mem_addr, d_mem_addr, mem_addr;
    cache_line_t       i_mem_wdata, d_mem_wdata;
    logic [LINE_W-1:0] i_mem_rdata, d_mem_rdata, mem_wdata;
    logic              i_mem_rw, d_mem_rw, mem_rw;
    logic              i_mem_valid, d_mem_valid, mem_valid;
    logic              i_mem_ready, d_mem_ready, mem_ready;
    cache_line_t       mem_rdata;

    cache_ctrl icache_i (
        .clk_i, .rst_ni,
        .cpu_addr_i (i_cpu_addr_i), .cpu_wdata_i(i_cpu_wdata_i),
        .cpu_rw_i   (i_cpu_rw_i),   .cpu_valid_i(i_cpu_valid_i),
        .cpu_rdata_o(i_cpu_rdata_o), .cpu_ready_o(i_cpu_ready_o),
        .mem_addr_o (i_mem_addr),   .mem_wdata_o(i_mem_wdata),
        .mem_rw_o   (i_mem_rw),     .mem_valid_o(i_mem_valid),
        .mem_rdata_i(i_mem_rdata),  .mem_ready_i(i_mem_ready)
    );

    cache_ctrl dcache_i (
        .clk_i, .rst_ni,
        .cpu_addr_i (d_cpu_addr_i), .cpu_wdata_i(d_cpu_wdata_i),
        .cpu_rw_i   (d_cpu_rw_i),   .cpu_valid_i(d_cpu_valid_i),
        .cpu_rdata_o(d_cpu_rdata_o), .cpu_ready_o(d_cpu_ready_o),
        .mem_addr_o (d_mem_addr),   .mem_wdata_o(d_mem_wdata),
        .mem_rw_o   (d_mem_rw),     .mem_valid_o(d_mem_valid),
        .mem_rdata_i(d_mem_rdata),  .mem_ready_i(d_mem_ready)
    );

    cache_arbiter cache_arbiter_i (
        .clk_i, .rst_ni,
        .i_req_addr_i (i_mem_addr),  .i_req_wdata_i(i_mem_wdata),
        .i_req_rw_i   (i_mem_rw),    .i_req_valid_i(i_mem_valid),
        .i_rsp_rdata_o(i_mem_rdata), .i_rsp_ready_o(i_mem_ready),
        .d_req_addr_i (d_mem_addr),  .d_req_wdata_i(d_mem_wdata),
        .d_req_rw_i   (d_mem_rw),    .d_req_valid_i(d_mem_valid),
        .d_rsp_rdata_o(d_mem_rdata), .d_rsp_ready_o(d_mem_ready),
        .mem_addr_o   (mem_addr),    .mem_wdata_o  (mem_wdata),
        .mem_rw_o     (mem_rw),      .mem_valid_o  (mem_valid),
        .mem_rdata_i  (mem_rdata),   .mem_ready_i  (mem_ready)
    );

    line_memory line_memory_i (
        .clk_i, .rst_ni,
        .mem_addr_i (mem_addr),  .mem_wdata_i(mem_wdata),
        .mem_rw_i   (mem_rw),    .mem_valid_i(mem_valid),
        .mem_rdata_o(mem_rdata), .mem_ready_o(mem_ready)
    );

endmodule

`default_nettype wire

/* hdl/line_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module line_memory
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic [ADDR_W-1:0] mem_addr_i,
    input  wire cache_line_t       mem_wdata_i,
    input  wire logic              mem_rw_i,
    input  wire logic              mem_valid_i,
    output cache_line_t            mem_rdata_o,
    output logic                   mem_ready_o
);

    enum logic [1:0] {MEM_IDLE, MEM_BUSY, MEM_RELEASE} state_q;

    logic [LAT_CNT_W-1:0] cnt_q;
    logic [MEM_IDX_W-1:0] idx;
    logic                 access;

    cache_line_t mem_q [MEM_LINES] = '{default: '0};

    assign idx    = mem_addr_i[MEM_IDX_LSB +: MEM_IDX_W];   // Upper bits alias.
    assign access = (state_q == MEM_BUSY) && (cnt_q == '0);

    // Count down, pulse ready, then wait for valid to go away.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= MEM_IDLE;
            cnt_q       <= '0;
            mem_ready_o <= 1'b0;
        end else begin
            mem_ready_o <= access;
            case (state_q)
                MEM_IDLE: begin
                    if (mem_valid_i) begin
                        cnt_q   <= LAT_CNT_W'(MEM_LATENCY - 1);
                        state_q <= MEM_BUSY;
                    end
                end
                MEM_BUSY: begin
                    if (access) state_q <= MEM_RELEASE;
                    else cnt_q <= cnt_q - 1'b1;
                end
                MEM_RELEASE: begin
                    if (!mem_valid_i && !mem_ready_o) state_q <= MEM_IDLE;
                end
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (mem_rw_i) mem_q[idx] <= mem_wdata_i;
            else mem_rdata_o <= mem_q[idx];
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_arbiter
    import mem_bus_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic [ADDR_W-1:0] i_req_addr_i,
    input  wire logic [LINE_W-1:0] i_req_wdata_i,
    input  wire logic              i_req_rw_i,
    input  wire logic              i_req_valid_i,
    output logic      [LINE_W-1:0] i_rsp_rdata_o,
    output logic                   i_rsp_ready_o,

    input  wire logic [ADDR_W-1:0] d_req_addr_i,
    input  wire logic [LINE_W-1:0] d_req_wdata_i,
    input  wire logic              d_req_rw_i,
    input  wire logic              d_req_valid_i,
    output logic      [LINE_W-1:0] d_rsp_rdata_o,
    output logic                   d_rsp_ready_o,

    output logic      [ADDR_W-1:0] mem_addr_o,
    output logic      [LINE_W-1:0] mem_wdata_o,
    output logic                   mem_rw_o,
    output logic                   mem_valid_o,
    input  wire logic [LINE_W-1:0] mem_rdata_i,
    input  wire logic              mem_ready_i
);

    enum logic [1:0] {IDLE, I_SIDE, D_SIDE} state_q, state_d;

    // Grant held while the owner stays valid. I side wins a tie.
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req_valid_i) state_d = I_SIDE;
                else if (d_req_valid_i) state_d = D_SIDE;
            end
            I_SIDE: begin
                if (!i_req_valid_i) state_d = d_req_valid_i ? D_SIDE : IDLE;
            end
            D_SIDE: begin
                if (!d_req_valid_i) state_d = i_req_valid_i ? I_SIDE : IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    // ******************************
    // Steering
    // ******************************

    always_comb begin
        mem_addr_o    = '0;
        mem_wdata_o   = '0;
        mem_rw_o      = 1'b0;
        mem_valid_o   = 1'b0;
        i_rsp_rdata_o = '0;
        i_rsp_ready_o = 1'b0;
        d_rsp_rdata_o = '0;
        d_rsp_ready_o = 1'b0;

        if (state_q == I_SIDE) begin
            mem_addr_o    = i_req_addr_i;
            mem_wdata_o   = i_req_wdata_i;
            mem_rw_o      = i_req_rw_i;
            mem_valid_o   = i_req_valid_i;
            i_rsp_rdata_o = mem_rdata_i;
            i_rsp_ready_o = mem_ready_i;
        end else if (state_q == D_SIDE) begin
            mem_addr_o    = d_req_addr_i;
            mem_wdata_o   = d_req_wdata_i;
            mem_rw_o      = d_req_rw_i;
            mem_valid_o   = d_req_valid_i;
            d_rsp_rdata_o = mem_rdata_i;
            d_rsp_ready_o = mem_ready_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic [ADDR_W-1:0] cpu_addr_i,
    input  wire logic [WORD_W-1:0] cpu_wdata_i,
    input  wire logic              cpu_rw_i,
    input  wire logic              cpu_valid_i,
    output logic      [WORD_W-1:0] cpu_rdata_o,
    output logic                   cpu_ready_o,

    output logic      [ADDR_W-1:0] mem_addr_o,
    output cache_line_t            mem_wdata_o,
    output logic                   mem_rw_o,
    output logic                   mem_valid_o,
    input  wire cache_line_t       mem_rdata_i,
    input  wire logic              mem_ready_i
);

    enum logic [1:0] {IDLE, COMPARE_TAG, ALLOCATE, WRITE_THROUGH} state_q, state_d;

    // ******************************
    // Arrays
    // ******************************

    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    cache_line_t            data_q [CACHE_LINES];

    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic                hit;
    cache_line_t         cur_line;
    cache_line_t         merged_line;
    logic                install;   // Fill from next level.
    logic                merge;     // Write hit.

    assign idx    = cpu_addr_i[INDEX_LSB +: INDEX_W];
    assign tag    = cpu_addr_i[TAG_LSB +: TAG_W];
    assign offset = cpu_addr_i[OFFSET_LSB +: OFFSET_W];

    assign cur_line = data_q[idx];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    // New word dropped into the current line.
    always_comb begin
        merged_line = cur_line;
        merged_line.words[offset] = cpu_wdata_i;
    end

    assign cpu_rdata_o = cur_line.words[offset];

    // Line aligned. Write data is the already merged line.
    assign mem_addr_o  = {cpu_addr_i[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    assign mem_wdata_o = cur_line;

    // ******************************
    // Controller
    // ******************************

    always_comb begin
        state_d     = state_q;
        cpu_ready_o = 1'b0;
        mem_valid_o = 1'b0;
        mem_rw_o    = 1'b0;
        install     = 1'b0;
        merge       = 1'b0;

        case (state_q)
            IDLE: begin
                if (cpu_valid_i) begin
                    state_d = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (!hit) begin
                    state_d = ALLOCATE;   // Read and write miss alike.
                end else if (cpu_rw_i) begin
                    merge   = 1'b1;
                    state_d = WRITE_THROUGH;
                end else begin
                    cpu_ready_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            ALLOCATE: begin
                mem_valid_o = 1'b1;
                if (mem_ready_i) begin
                    install = 1'b1;
                    state_d = COMPARE_TAG;   // Retry as a hit.
                end
            end
            WRITE_THROUGH: begin
                mem_valid_o = 1'b1;
                mem_rw_o    = 1'b1;
                if (mem_ready_i) begin
                    cpu_ready_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (install) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (install) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rdata_i;
        end else if (merge) begin
            data_q[idx] <= merged_line;
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    // ******************************
    // Geometry
    // ******************************

    localparam int unsigned WORD_W         = 32;
    localparam int unsigned WORDS_PER_LINE = 4;

    // Address fields.
    localparam int unsigned OFFSET_LSB = 2;
    localparam int unsigned OFFSET_W   = $clog2(WORDS_PER_LINE);
    localparam int unsigned INDEX_LSB  = OFFSET_LSB + OFFSET_W;
    localparam int unsigned INDEX_W    = 6;
    localparam int unsigned TAG_LSB    = INDEX_LSB + INDEX_W;
    localparam int unsigned TAG_W      = 22;   // Up to bit 31.

    localparam int unsigned CACHE_LINES = 2 ** INDEX_W;

    // Whole line on the bus, word view for select and merge.
    typedef union packed {
        logic [WORDS_PER_LINE*WORD_W-1:0]     flat;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } cache_line_t;

endpackage

`default_nettype wire

/* hdl/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // ******************************
    // Shared line bus
    // ******************************

    localparam int unsigned ADDR_W = 32;   // Byte address.
    localparam int unsigned LINE_W = 128;

    // ******************************
    // Backing memory
    // ******************************

    localparam int unsigned MEM_LINES   = 256;
    localparam int unsigned MEM_IDX_LSB = 4;   // 16-byte lines.
    localparam int unsigned MEM_IDX_W   = $clog2(MEM_LINES);

    // Request sampled to ready pulse.
    localparam int unsigned MEM_LATENCY = 3;
    localparam int unsigned LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

endpackage

`default_nettype wire
